/* stream_to_ram.f */
+incdir+.
s2r_pkg.sv
s2r_fifo.sv
s2r_block_tracker.sv
s2r_aw_issuer.sv
s2r_w_streamer.sv
stream_to_ram.sv
tb_clock_gen.sv
tb_stream_to_ram.sv

/* Makefile */
# Verilator build and run for the stream-to-RAM writer testbench

VERILATOR ?= verilator
TOP       ?= tb_stream_to_ram
FILELIST  ?= stream_to_ram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_stream_to_ram.sv */
/*
   Testbench for the stream-to-RAM writer with two inflows under random stalls
   A memory-side responder answers bursts, and assertions on the falling edge check the DUT
*/

`default_nettype none
`timescale 1ns/1ps

`include "s2r_defines.svh"

module tb_stream_to_ram;

   localparam int          BLOCK      = `S2R_BLOCK_CYCLES;
   localparam logic [63:0] BURST      = 64'(`S2R_BURST_BYTES);
   localparam int          FIFO_DEPTH = `S2R_FIFO_DEPTH;
   localparam int          RUN1_BEATS = 43;
   localparam int          RUN2_BEATS = 37;
   // Two runs of about 40 beats, with up to 50 cycles per beat under stalls
   localparam int          TIMEOUT_CYCLES = 2 * 40 * 50;

   logic                   clk;
   logic                   resetn;
   logic                   inflow   = 1'b0;
   logic [`S2R_DATA_W-1:0] in_data  = '0;
   logic                   in_valid = 1'b0;
   logic                   in_ready;
   s2r_pkg::aw_req_t       aw;
   logic                   awvalid;
   logic                   awready  = 1'b0;
   logic [`S2R_DATA_W-1:0] wdata;
   logic                   wvalid;
   logic                   wlast;
   logic                   wready   = 1'b0;
   logic                   bvalid   = 1'b0;
   logic                   bready;
   logic [31:0]            cycles_rcvd;
   logic [31:0]            full_blocks;
   logic [7:0]             partial_cycles;
   logic                   has_data;
   logic                   done;
   logic [63:0]            hwm;

   integer seed     = 32'ha5b2;
   int     run_no   = 0;
   int     cycle_count = 0;
   logic   stall_in = 1'b0;

   // Reference state, updated on the rising edge
   logic             prev_inflow;
   logic [31:0]      beat_cnt;
   logic [31:0]      w_beats;
   logic [31:0]      aw_count;
   logic [31:0]      ack_cnt;
   logic [63:0]      exp_hwm;
   logic             aw_pending;
   s2r_pkg::aw_req_t aw_held;

   // Memory-side responder state
   logic [31:0] aw_acc;
   logic [31:0] w_done;
   logic [31:0] b_sent;
   logic [1:0]  b_wait;

   // Expected values, derived from the reference state and the current inputs
   logic        new_inflow_tb;
   logic        in_fire_tb;
   logic        exp_in_ready;
   logic [31:0] exp_cycles;
   logic [31:0] exp_full;
   logic [31:0] exp_bursts;
   logic [31:0] ready_bursts;
   logic [7:0]  exp_partial;
   logic [7:0]  exp_len;
   logic [63:0] exp_addr;
   logic [63:0] exp_wdata;
   logic        exp_wlast;
   logic        exp_done;

   tb_clock_gen i_clock_gen (
      .clk    (clk),
      .resetn (resetn)
   );

   stream_to_ram i_stream_to_ram (
      .clk            (clk),
      .resetn         (resetn),
      .inflow         (inflow),
      .in_data        (in_data),
      .in_valid       (in_valid),
      .in_ready       (in_ready),
      .aw             (aw),
      .awvalid        (awvalid),
      .awready        (awready),
      .wdata          (wdata),
      .wvalid         (wvalid),
      .wlast          (wlast),
      .wready         (wready),
      .bvalid         (bvalid),
      .bready         (bready),
      .cycles_rcvd    (cycles_rcvd),
      .full_blocks    (full_blocks),
      .partial_cycles (partial_cycles),
      .has_data       (has_data),
      .done           (done),
      .hwm            (hwm)
   );

   // Each beat carries its run and its index, so order errors show up in the data
   function automatic logic [63:0] beat_value(input int run, input logic [31:0] idx);
      return {8'(run), 24'(idx), idx * 32'h9e37_79b1};
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
      $display("Verification failed");
      $fatal(1);
   endtask

   // ========================================
   // Reference model
   // ========================================

   always_comb begin
      new_inflow_tb = inflow & ~prev_inflow;
      in_fire_tb    = in_valid & in_ready;
      // Beats accepted but not yet written are what fills the FIFO
      exp_in_ready  = (beat_cnt - w_beats) != 32'(FIFO_DEPTH);
      // A new inflow restarts the count, and a beat in flight already counts
      exp_cycles  = new_inflow_tb ? 32'(in_fire_tb) : beat_cnt + 32'(in_fire_tb);
      exp_full    = exp_cycles / 32'(BLOCK);
      exp_partial = inflow ? 8'd0 : 8'(exp_cycles % 32'(BLOCK));
      exp_bursts  = exp_full + 32'(exp_partial != 8'd0);
      exp_done    = ~inflow & (ack_cnt == exp_bursts);
      // Requests past the full blocks can only be the tail
      exp_len     = (aw_count < exp_full) ? 8'(BLOCK - 1) : exp_partial - 8'd1;
      exp_addr    = `S2R_RAM_BASE + 64'(aw_count) * BURST;
      exp_wdata   = beat_value(run_no, w_beats);
      exp_wlast   = (w_beats % 32'(BLOCK) == 32'(BLOCK - 1)) ||
                    (!inflow && (w_beats + 32'd1 == beat_cnt));
      ready_bursts = (aw_acc < w_done) ? aw_acc : w_done;
   end

   always @(posedge clk) begin
      if (!resetn) begin
         prev_inflow <= 1'b0;
         beat_cnt    <= '0;
         w_beats     <= '0;
         aw_count    <= '0;
         ack_cnt     <= '0;
         exp_hwm     <= '0;
         aw_pending  <= 1'b0;
         aw_held     <= '0;
      end else begin
         prev_inflow <= inflow;
         // A request cut short by a new inflow need not stay up
         aw_pending  <= awvalid & ~awready & ~new_inflow_tb;
         aw_held     <= aw;
         if (new_inflow_tb) begin
            beat_cnt <= 32'(in_fire_tb);
            w_beats  <= '0;
            aw_count <= '0;
            ack_cnt  <= '0;
         end else begin
            if (in_fire_tb)
               beat_cnt <= beat_cnt + 32'd1;
            if (wvalid && wready)
               w_beats <= w_beats + 32'd1;
            if (awvalid && awready)
               aw_count <= aw_count + 32'd1;
            if (bvalid && bready)
               ack_cnt <= ack_cnt + 32'd1;
         end
         // The mark is never cleared by a new inflow
         if (awvalid && awready && (64'(aw_count + 32'd1) * BURST > exp_hwm))
            exp_hwm <= 64'(aw_count + 32'd1) * BURST;
      end
   end

   // ========================================
   // Memory-side responder
   // ========================================

   // One response per burst whose address and last data beat were both accepted
   always @(posedge clk) begin
      if (!resetn) begin
         awready  <= 1'b0;
         wready   <= 1'b0;
         bvalid   <= 1'b0;
         stall_in <= 1'b0;
         aw_acc   <= '0;
         w_done   <= '0;
         b_sent   <= '0;
         b_wait   <= '0;
      end else begin
         awready  <= ($random(seed) & 3) != 0;
         wready   <= ($random(seed) & 3) != 0;
         stall_in <= ($random(seed) & 3) == 0;
         if (awvalid && awready)
            aw_acc <= aw_acc + 32'd1;
         if (wvalid && wready && wlast)
            w_done <= w_done + 32'd1;
         if (bvalid && bready) begin
            bvalid <= 1'b0;
            b_sent <= b_sent + 32'd1;
         end else if (!bvalid && (b_sent < ready_bursts)) begin
            // Random gap of up to three cycles before each response
            if (b_wait == 2'd0) begin
               bvalid <= 1'b1;
               b_wait <= 2'($random(seed));
            end else begin
               b_wait <= b_wait - 2'd1;
            end
         end
      end
   end

   // ========================================
   // Assertions
   // ========================================

   cycles_match: assert property (@(negedge clk) disable iff (!resetn)
      cycles_rcvd == exp_cycles)
      else report_mismatch("cycles_rcvd", 64'(cycles_rcvd), 64'(exp_cycles));
   full_match: assert property (@(negedge clk) disable iff (!resetn)
      full_blocks == exp_full)
      else report_mismatch("full_blocks", 64'(full_blocks), 64'(exp_full));
   partial_match: assert property (@(negedge clk) disable iff (!resetn)
      partial_cycles == exp_partial)
      else report_mismatch("partial_cycles", 64'(partial_cycles), 64'(exp_partial));
   has_data_match: assert property (@(negedge clk) disable iff (!resetn)
      has_data == (exp_cycles != 32'd0))
      else report_mismatch("has_data", 64'(has_data), 64'(exp_cycles != 32'd0));
   done_match: assert property (@(negedge clk) disable iff (!resetn)
      done == exp_done)
      else report_mismatch("done", 64'(done), 64'(exp_done));
   hwm_match: assert property (@(negedge clk) disable iff (!resetn)
      hwm == exp_hwm)
      else report_mismatch("hwm", hwm, exp_hwm);

   // The stream is accepted whenever the FIFO has room
   in_ready_match: assert property (@(negedge clk) disable iff (!resetn)
      in_ready == exp_in_ready)
      else report_mismatch("in_ready", 64'(in_ready), 64'(exp_in_ready));
   // Write responses are taken in every cycle out of reset
   bready_high: assert property (@(negedge clk) disable iff (!resetn)
      bready)
      else report_mismatch("bready", 64'(bready), 64'd1);

   // Requests step through RAM from the base address
   aw_addr_match: assert property (@(negedge clk) disable iff (!resetn)
      awvalid |-> aw.addr == exp_addr)
      else report_mismatch("aw.addr", aw.addr, exp_addr);
   aw_len_match: assert property (@(negedge clk) disable iff (!resetn)
      awvalid |-> aw.len == exp_len)
      else report_mismatch("aw.len", 64'(aw.len), 64'(exp_len));

   // A stalled request stays up and unchanged
   aw_valid_held: assert property (@(negedge clk) disable iff (!resetn)
      aw_pending |-> awvalid)
      else report_mismatch("awvalid", 64'(awvalid), 64'd1);
   aw_addr_held: assert property (@(negedge clk) disable iff (!resetn)
      aw_pending |-> aw.addr == aw_held.addr)
      else report_mismatch("aw.addr", aw.addr, aw_held.addr);
   aw_len_held: assert property (@(negedge clk) disable iff (!resetn)
      aw_pending |-> aw.len == aw_held.len)
      else report_mismatch("aw.len", 64'(aw.len), 64'(aw_held.len));

   wdata_match: assert property (@(negedge clk) disable iff (!resetn)
      wvalid |-> wdata == exp_wdata)
      else report_mismatch("wdata", wdata, exp_wdata);
   wlast_match: assert property (@(negedge clk) disable iff (!resetn)
      wvalid |-> wlast == exp_wlast)
      else report_mismatch("wlast", 64'(wlast), 64'(exp_wlast));

   // ========================================
   // Stimulus
   // ========================================

   // Sends n beats in one inflow, ends it, and waits until every burst is acknowledged
   task automatic run_inflow(input int run, input int n);
      int sent;
      sent   = 0;
      run_no = run;
      @(posedge clk);
      inflow <= 1'b1;
      while (sent < n) begin
         @(posedge clk);
         in_data  <= beat_value(run, 32'(sent));
         in_valid <= ~stall_in;
         // Handshake is judged mid-cycle, where all signals are settled
         @(negedge clk);
         if (in_valid && in_ready)
            sent = sent + 1;
      end
      // The last beat transfers on this edge
      @(posedge clk);
      in_valid <= 1'b0;
      inflow   <= 1'b0;
      @(negedge clk);
      while (!done)
         @(negedge clk);
   endtask

   // Totals for the run that just completed
   task automatic check_run_totals(input int n);
      logic [31:0] bursts;
      bursts = 32'((n + BLOCK - 1) / BLOCK);
      assert (cycles_rcvd == 32'(n))
         else report_mismatch("cycles_rcvd", 64'(cycles_rcvd), 64'(n));
      assert (w_beats == 32'(n))
         else report_mismatch("wdata beat count", 64'(w_beats), 64'(n));
      assert (aw_count == bursts)
         else report_mismatch("aw request count", 64'(aw_count), 64'(bursts));
   endtask

   initial begin
      while (!resetn)
         @(posedge clk);
      run_inflow(1, RUN1_BEATS);
      check_run_totals(RUN1_BEATS);
      repeat (5) @(posedge clk);
      // Second run is shorter, so the mark from the first run must survive
      run_inflow(2, RUN2_BEATS);
      check_run_totals(RUN2_BEATS);
      $display("Verification passed");
      $finish;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
/*
   Clock and reset source for the testbench
   Reset stays low for a set number of rising edges after time zero
*/

`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 2,
   parameter int RESET_CYCLES   = 2
) (
   output logic clk,
   output logic resetn
);

   // Free-running clock with a 4 ns period at the default setting
   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   // Reset is released on a rising edge, like every other synchronous input
   initial begin
      resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      resetn <= 1'b1;
   end

endmodule

`default_nettype wire

/* stream_to_ram.sv */
/*
   Stream-to-RAM writer top level
   Buffers the input stream and writes it to memory as AXI4 write bursts
*/

`default_nettype none
`timescale 1ns/1ps

`include "s2r_defines.svh"

module stream_to_ram (
   input  wire                     clk,
   input  wire                     resetn,
   input  wire                     inflow,
   // Input stream
   input  wire  [`S2R_DATA_W-1:0]  in_data,
   input  wire                     in_valid,
   output logic                    in_ready,
   // Write-address channel
   output s2r_pkg::aw_req_t        aw,
   output logic                    awvalid,
   input  wire                     awready,
   // Write-data channel
   output logic [`S2R_DATA_W-1:0]  wdata,
   output logic                    wvalid,
   output logic                    wlast,
   input  wire                     wready,
   // Write-response channel
   input  wire                     bvalid,
   output logic                    bready,
   // Status
   output logic [31:0]             cycles_rcvd,
   output logic [31:0]             full_blocks,
   output logic [7:0]              partial_cycles,
   output logic                    has_data,
   output logic                    done,
   output logic [63:0]             hwm
);

   s2r_pkg::block_status_t status;
   logic                   in_fire;
   logic                   pop_valid;
   logic                   pop_ready;

   // A beat is accepted when the stream offers it and the FIFO has room
   assign in_fire = in_valid & in_ready;

   assign full_blocks    = status.full_blocks;
   assign partial_cycles = status.partial_cycles;

   s2r_fifo i_fifo (
      .clk        (clk),
      .resetn     (resetn),
      .push_data  (in_data),
      .push_valid (in_valid),
      .push_ready (in_ready),
      .pop_data   (wdata),
      .pop_valid  (pop_valid),
      .pop_ready  (pop_ready)
   );

   s2r_block_tracker i_block_tracker (
      .clk         (clk),
      .resetn      (resetn),
      .inflow      (inflow),
      .in_fire     (in_fire),
      .bvalid      (bvalid),
      .status      (status),
      .cycles_rcvd (cycles_rcvd),
      .has_data    (has_data),
      .done        (done),
      .bready      (bready)
   );

   s2r_aw_issuer i_aw_issuer (
      .clk     (clk),
      .resetn  (resetn),
      .status  (status),
      .aw      (aw),
      .awvalid (awvalid),
      .awready (awready),
      .hwm     (hwm)
   );

   s2r_w_streamer i_w_streamer (
      .clk       (clk),
      .resetn    (resetn),
      .status    (status),
      .pop_valid (pop_valid),
      .pop_ready (pop_ready),
      .wvalid    (wvalid),
      .wready    (wready),
      .wlast     (wlast)
   );

endmodule

`default_nettype wire

/* s2r_w_streamer.sv */
/*
   Moves beats from the FIFO head onto the write-data channel in bursts,
   marking the last beat of each burst
*/

`default_nettype none
`timescale 1ns/1ps

`include "s2r_defines.svh"

module s2r_w_streamer (
   input  wire                     clk,
   input  wire                     resetn,
   input  wire s2r_pkg::block_status_t status,
   input  wire                     pop_valid,
   output logic                    pop_ready,
   output logic                    wvalid,
   input  wire                     wready,
   output logic                    wlast
);

   s2r_pkg::w_state_e state;
   logic [31:0]       w_blocks;
   logic [7:0]        remaining;
   logic              sending;
   logic              w_fire;

   // Data moves only while a burst is open
   assign sending   = (state == s2r_pkg::W_FULL) || (state == s2r_pkg::W_FINAL);
   assign wvalid    = sending & pop_valid;
   // The head is popped only on a handshake, so a stalled beat stays put
   assign pop_ready = sending & wready;
   assign w_fire    = wvalid & wready;

   // One beat left in the burst means this is its last
   assign wlast = (remaining == 8'd1);

   always_ff @(posedge clk) begin
      if (!resetn || status.new_inflow) begin
         state     <= s2r_pkg::W_IDLE;
         w_blocks  <= '0;
         remaining <= '0;
      end else begin
         case (state)
            s2r_pkg::W_IDLE: begin
               if (w_blocks < status.full_blocks) begin
                  remaining <= 8'(`S2R_BLOCK_CYCLES);
                  w_blocks  <= w_blocks + 1'b1;
                  state     <= s2r_pkg::W_FULL;
               end else if (status.partial_cycles != 8'd0) begin
                  remaining <= status.partial_cycles;
                  state     <= s2r_pkg::W_FINAL;
               end
            end
            // Back-to-back full bursts run without a gap when blocks are ready
            s2r_pkg::W_FULL: begin
               if (w_fire) begin
                  remaining <= remaining - 8'd1;
                  if (wlast) begin
                     if (w_blocks < status.full_blocks) begin
                        remaining <= 8'(`S2R_BLOCK_CYCLES);
                        w_blocks  <= w_blocks + 1'b1;
                     end else begin
                        state <= s2r_pkg::W_IDLE;
                     end
                  end
               end
            end
            s2r_pkg::W_FINAL: begin
               if (w_fire) begin
                  remaining <= remaining - 8'd1;
                  if (wlast)
                     state <= s2r_pkg::W_FINISHED;
               end
            end
            // Tail written; wait here for the next inflow
            s2r_pkg::W_FINISHED: state <= s2r_pkg::W_FINISHED;
            default: state <= s2r_pkg::W_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* s2r_aw_issuer.sv */
/*
   Issues write-address requests, one per full block plus one for the tail,
   and keeps the high-water mark of RAM usage across inflows
*/

`default_nettype none
`timescale 1ns/1ps

`include "s2r_defines.svh"

module s2r_aw_issuer (
   input  wire                     clk,
   input  wire                     resetn,
   input  wire s2r_pkg::block_status_t status,
   output s2r_pkg::aw_req_t        aw,
   output logic                    awvalid,
   input  wire                     awready,
   output logic [63:0]             hwm
);

   s2r_pkg::aw_state_e state;
   logic [31:0]        aw_blocks;
   logic [63:0]        ram_usage;
   logic               aw_fire;

   assign aw_fire = awvalid & awready;

   // Bytes of RAM in use once the current request lands, counted as a full burst
   assign ram_usage = (aw.addr - `S2R_RAM_BASE) + 64'(`S2R_BURST_BYTES);

   // ========================================
   // High-water mark
   // ========================================

   // Only a power-on reset clears the mark, so it survives a new inflow
   always_ff @(posedge clk) begin
      if (!resetn)
         hwm <= '0;
      else if (aw_fire && (ram_usage > hwm))
         hwm <= ram_usage;
   end

   // ========================================
   // Request FSM
   // ========================================

   always_ff @(posedge clk) begin
      if (!resetn || status.new_inflow) begin
         aw.addr   <= `S2R_RAM_BASE;
         awvalid   <= 1'b0;
         aw_blocks <= '0;
         state     <= s2r_pkg::AW_IDLE;
      end else begin
         case (state)
            // Full blocks waiting take priority over the tail
            s2r_pkg::AW_IDLE: begin
               if (status.full_blocks > aw_blocks) begin
                  aw.len  <= 8'(`S2R_BLOCK_CYCLES - 1);
                  awvalid <= 1'b1;
                  state   <= s2r_pkg::AW_FULL;
               end else if (status.partial_cycles != 8'd0) begin
                  aw.len  <= status.partial_cycles - 8'd1;
                  awvalid <= 1'b1;
                  state   <= s2r_pkg::AW_FINAL;
               end
            end
            // Hold the request until accepted, then step to the next block
            s2r_pkg::AW_FULL: begin
               if (aw_fire) begin
                  aw.addr   <= aw.addr + 64'(`S2R_BURST_BYTES);
                  awvalid   <= 1'b0;
                  aw_blocks <= aw_blocks + 1'b1;
                  state     <= s2r_pkg::AW_IDLE;
               end
            end
            s2r_pkg::AW_FINAL: begin
               if (aw_fire) begin
                  awvalid <= 1'b0;
                  state   <= s2r_pkg::AW_HOLD;
               end
            end
            // Nothing more to issue until the next inflow restarts the engine
            s2r_pkg::AW_HOLD: state <= s2r_pkg::AW_HOLD;
            default: state <= s2r_pkg::AW_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* s2r_block_tracker.sv */
/*
   Watches the inflow flag and the input stream, counts beats and blocks,
   and counts write responses to decide when all data has reached memory
*/

`default_nettype none
`timescale 1ns/1ps

`include "s2r_defines.svh"

module s2r_block_tracker (
   input  wire                     clk,
   input  wire                     resetn,
   input  wire                     inflow,
   input  wire                     in_fire,
   input  wire                     bvalid,
   output s2r_pkg::block_status_t  status,
   output logic [31:0]             cycles_rcvd,
   output logic                    has_data,
   output logic                    done,
   output logic                    bready
);

   logic        prev_inflow;
   logic        new_inflow;
   logic [31:0] cycles_q;
   logic [31:0] acks_rcvd;
   logic [31:0] total_writes;

   // ========================================
   // New inflow detection
   // ========================================

   always_ff @(posedge clk) begin
      if (!resetn)
         prev_inflow <= 1'b0;
      else
         prev_inflow <= inflow;
   end

   // A rising edge on inflow starts a new run
   assign new_inflow = inflow & ~prev_inflow;

   // ========================================
   // Beat and block counting
   // ========================================

   // On a new inflow the count restarts at 0 or at 1, depending on this cycle's beat
   always_ff @(posedge clk) begin
      if (!resetn)
         cycles_q <= '0;
      else if (new_inflow)
         cycles_q <= 32'(in_fire);
      else if (in_fire)
         cycles_q <= cycles_q + 1'b1;
   end

   // The reported count already includes a beat that is transferring right now
   assign cycles_rcvd = new_inflow ? 32'(in_fire) : cycles_q + 32'(in_fire);

   assign status.new_inflow     = new_inflow;
   assign status.full_blocks    = cycles_rcvd / `S2R_BLOCK_CYCLES;
   // The tail only counts once no more data can arrive
   assign status.partial_cycles = inflow ? 8'd0 : 8'(cycles_rcvd % `S2R_BLOCK_CYCLES);

   assign has_data = (cycles_rcvd != '0);

   // ========================================
   // Write responses and completion
   // ========================================

   // Responses are always accepted once the design is out of reset
   assign bready = resetn;

   always_ff @(posedge clk) begin
      if (!resetn || new_inflow)
         acks_rcvd <= '0;
      else if (bvalid && bready)
         acks_rcvd <= acks_rcvd + 1'b1;
   end

   // Every full block is one burst, and a nonzero tail adds one more
   assign total_writes = status.full_blocks + 32'(status.partial_cycles != 8'd0);

   // Done once inflow has ended and every burst has been acknowledged
   assign done = ~inflow & (acks_rcvd == total_writes);

endmodule

`default_nettype wire

/* s2r_fifo.sv */
/*
   Synchronous FIFO between the input stream and the write-data engine
   Push and pop both use a valid/ready handshake
*/

`default_nettype none
`timescale 1ns/1ps

`include "s2r_defines.svh"

module s2r_fifo (
   input  wire                     clk,
   input  wire                     resetn,
   input  wire  [`S2R_DATA_W-1:0]  push_data,
   input  wire                     push_valid,
   output logic                    push_ready,
   output logic [`S2R_DATA_W-1:0]  pop_data,
   output logic                    pop_valid,
   input  wire                     pop_ready
);

   localparam int DEPTH = `S2R_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   logic [`S2R_DATA_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [PTR_W:0]         count;
   logic                   push_fire;
   logic                   pop_fire;

   assign push_ready = (count != (PTR_W+1)'(DEPTH));
   assign pop_valid  = (count != '0);
   assign push_fire  = push_valid & push_ready;
   assign pop_fire   = pop_valid & pop_ready;

   // The head is read straight from storage, so a pushed beat shows up a cycle later
   assign pop_data = mem[rd_ptr];

   // Each accepted beat is written at the tail
   always_ff @(posedge clk) begin
      if (push_fire)
         mem[wr_ptr] <= push_data;
   end

   // Pointers wrap at the end of the buffer and the count tracks occupancy
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_fire)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop_fire)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // A push and a pop in the same cycle leave the count unchanged
         if (push_fire && !pop_fire)
            count <= count + 1'b1;
         else if (pop_fire && !push_fire)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* s2r_pkg.sv */
/*
   Types shared between the tracker and the two channel engines
*/

`default_nettype none

package s2r_pkg;

   // Block status that the tracker hands to both engines
   typedef struct packed {
      // Completed full blocks, including a beat arriving this cycle
      logic [31:0] full_blocks;
      // Beats in the trailing partial block, zero while data still flows
      logic [7:0]  partial_cycles;
      // High for the one cycle in which a new inflow starts
      logic        new_inflow;
   } block_status_t;

   // One request on the write-address channel
   typedef struct packed {
      logic [63:0] addr;
      // Burst length minus one, as the channel encodes it
      logic [7:0]  len;
   } aw_req_t;

   // Write-address engine states
   typedef enum logic [1:0] {
      AW_IDLE,
      AW_FULL,
      AW_FINAL,
      AW_HOLD
   } aw_state_e;

   // Write-data engine states
   typedef enum logic [1:0] {
      W_IDLE,
      W_FULL,
      W_FINAL,
      W_FINISHED
   } w_state_e;

endpackage

`default_nettype wire

/* s2r_defines.svh */
/*
   Shared constants for the stream-to-RAM writer
   Included by every module that needs a width, a length or an address
*/

`ifndef S2R_DEFINES_SVH
`define S2R_DEFINES_SVH

// Width of one stream beat, which is also the width of the write-data channel
`define S2R_DATA_W 64

// Number of beats in one full burst to memory
`define S2R_BLOCK_CYCLES 8

// Bytes covered by one full burst
`define S2R_BURST_BYTES (`S2R_BLOCK_CYCLES * (`S2R_DATA_W / 8))

// First RAM address written after every new inflow
`define S2R_RAM_BASE 64'h0000_0001_0000_0000

// The FIFO holds four full blocks of beats
`define S2R_FIFO_DEPTH (4 * `S2R_BLOCK_CYCLES)

`endif
